/* bench/lspcModel.svh */
// LSPC reference model
// Expected timing, register reads and auto-animation state for the testbench

`ifndef LSPC_MODEL_SVH
`define LSPC_MODEL_SVH

	// Shadow copies of the CPU-visible state
	logic [dataWidth-1:0] shadowRam [ramDepth];
	int shadowAddr = 0;
	logic [dataWidth-1:0] shadowMod = '0;
	logic [aaSpeedWidth-1:0] shadowSpeed = '0;
	bit shadowDisable = 1'b0;
	// Frames counted toward the next step
	int shadowDiv = 0;
	logic [aaCountWidth-1:0] shadowAa = '0;
	// Clock edges since reset release
	int cycle = 0;
	// Pending read answer
	bit expValid = 1'b0;
	logic [dataWidth-1:0] expData = '0;

	// ==================================================
	// Video timing
	// ==================================================

	function automatic int pixelAt(input int k);
		return k % lineLength;
	endfunction

	function automatic int rasterAt(input int k);
		return (k / lineLength) % linesPerFrame;
	endfunction

	// Inactive until the first clock after reset
	function automatic logic hsyncAt(input int k);
		if (k == 0)
			return 1'b1;
		return pixelAt(k) >= hsyncWidth;
	endfunction

	// No vertical sync during the first frame
	function automatic logic vsyncAt(input int k);
		if (k < frameCycles)
			return 1'b1;
		return rasterAt(k) >= vsyncLines;
	endfunction

	// Counter origin, not the one right after reset
	function automatic bit frameStartAt(input int k);
		return (k >= frameCycles) && (k % frameCycles == 0);
	endfunction

	// ==================================================
	// Register reads
	// ==================================================

	// Read word from the state before the sampling edge
	function automatic logic [dataWidth-1:0] regRead(input logic [regAddrWidth-1:0] idx,
		input int k);
		logic [rasterWidth-1:0] line;
		line = rasterWidth'(rasterAt(k));
		case (idx)
			regVramAddr, regVramRw:
				return shadowRam[shadowAddr];
			regVramMod:
				return shadowMod;
			regLspcMode:
				return {line, 4'b0000, shadowAa};
			default:
				return '0;
		endcase
	endfunction

	// Write takes effect at the sampling edge
	task automatic applyWrite(input logic [regAddrWidth-1:0] idx,
		input logic [dataWidth-1:0] data);
		case (idx)
			regVramAddr:
				shadowAddr = int'(data) % ramDepth;
			regVramRw:
			begin
				shadowRam[shadowAddr] = data;
				shadowAddr = (shadowAddr + int'(shadowMod)) % ramDepth;
			end
			regVramMod:
				shadowMod = data;
			regLspcMode:
			begin
				shadowSpeed = data[15:8];
				shadowDisable = data[3];
			end
			default:
				shadowMod = shadowMod;
		endcase
	endtask

	task automatic resetModel();
		shadowAddr = 0;
		shadowMod = '0;
		shadowSpeed = '0;
		shadowDisable = 1'b0;
		shadowDiv = 0;
		shadowAa = '0;
		cycle = 0;
		expValid = 1'b0;
	endtask

`endif

/* bench/lspcTb.sv */
// LSPC display core testbench
// Register port, VRAM, video timing and auto-animation against a reference model

`timescale 1ns/10ps

module lspcTb
	import lspcPkg::*;
;

	localparam int vramAddrWidth = 6;
	localparam int lineLength = 20;
	localparam int linesPerFrame = 12;
	localparam int hsyncWidth = 3;
	localparam int vsyncLines = 2;
	localparam int ramDepth = 2 ** vramAddrWidth;
	localparam int frameCycles = lineLength * linesPerFrame;
	localparam int clkPeriod = 4;
	localparam int resetCycles = 8;
	// Reset, three timing frames, 21 animation frames, register traffic
	localparam int testCycles = resetCycles + 24 * frameCycles + 400;
	localparam int watchdogNs = testCycles * 2 * clkPeriod;

	logic CLK_24M;
	logic T73A_OUT;
	logic [regAddrWidth-1:0] regAddr;
	logic [dataWidth-1:0] wrData;
	logic wrStrobe;
	logic rdStrobe;
	logic [dataWidth-1:0] rdData;
	logic rdValid;
	logic hsync;
	logic vsync;
	logic [aaCountWidth-1:0] aaCount;

	`include "lspcModel.svh"

	lspcTop #(
		.vramAddrWidth(vramAddrWidth), .lineLength(lineLength),
		.linesPerFrame(linesPerFrame), .hsyncWidth(hsyncWidth), .vsyncLines(vsyncLines)
	) i_lspcTop (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT), .regAddr(regAddr), .wrData(wrData),
		.wrStrobe(wrStrobe), .rdStrobe(rdStrobe), .rdData(rdData), .rdValid(rdValid),
		.hsync(hsync), .vsync(vsync), .aaCount(aaCount)
	);

	// ==================================================
	// Clock and watchdog
	// ==================================================

	initial
	begin
		CLK_24M = 1'b0;
		forever
			#(clkPeriod / 2) CLK_24M = ~CLK_24M;
	end

	initial
	begin
		#(watchdogNs);
		failRun("Watchdog expired before the test sequence finished");
	end

	// ==================================================
	// Failure reporting
	// ==================================================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			failRun($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// ==================================================
	// Model and compare
	// ==================================================

	// Model steps on the same edge as the DUT registers
	always @(posedge CLK_24M)
	begin
		if (!T73A_OUT)
			resetModel();
		else
		begin
			expValid = rdStrobe;
			if (rdStrobe)
				expData = regRead(regAddr, cycle);
			// Divider uses the speed before any write at this edge
			if (frameStartAt(cycle) && !shadowDisable)
			begin
				if (shadowDiv >= int'(shadowSpeed))
				begin
					shadowDiv = 0;
					shadowAa = shadowAa + 1'b1;
				end
				else
					shadowDiv++;
			end
			if (wrStrobe)
				applyWrite(regAddr, wrData);
			cycle++;
		end
	end

	// Outputs settled by the falling edge
	always @(negedge CLK_24M)
	begin
		if (rdValid !== expValid)
		begin
			if (expValid)
				failRun("rdValid missing one cycle after a read strobe");
			else
				failRun("rdValid high without a read strobe");
		end
		if (expValid)
			checkValue("rdData", rdData, expData);
		checkValue("hsync", hsync, hsyncAt(cycle));
		checkValue("vsync", vsync, vsyncAt(cycle));
		checkValue("aaCount", aaCount, shadowAa);
	end

	// ==================================================
	// Bus tasks entered 0.5 ns after a rising edge
	// ==================================================

	task automatic writeReg(input logic [regAddrWidth-1:0] idx,
		input logic [dataWidth-1:0] data);
		regAddr = idx;
		wrData = data;
		wrStrobe = 1'b1;
		@(posedge CLK_24M);
		#0.5;
		wrStrobe = 1'b0;
	endtask

	task automatic readReg(input logic [regAddrWidth-1:0] idx,
		output logic [dataWidth-1:0] data);
		regAddr = idx;
		rdStrobe = 1'b1;
		@(posedge CLK_24M);
		#0.5;
		rdStrobe = 1'b0;
		data = rdData;
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge CLK_24M);
			#0.5;
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	initial
	begin
		logic [dataWidth-1:0] words [8];
		logic [dataWidth-1:0] got;
		logic [dataWidth-1:0] first;
		logic [dataWidth-1:0] stride;
		logic [aaCountWidth-1:0] frozen;
		int base;
		int speed;
		T73A_OUT = 1'b0;
		regAddr = '0;
		wrData = '0;
		wrStrobe = 1'b0;
		rdStrobe = 1'b0;
		void'($urandom(32'hc899a44b));
		repeat (resetCycles)
			@(posedge CLK_24M);
		#0.5;
		T73A_OUT = 1'b1;

		// Modulo comes out of reset at zero
		readReg(regVramMod, got);
		checkValue("modulo after reset", got, 0);

		// Odd stride keeps all eight addresses distinct
		base = $urandom % ramDepth;
		stride = dataWidth'($urandom) | 16'h0001;
		writeReg(regVramMod, stride);
		writeReg(regVramAddr, dataWidth'(base));
		for (int i = 0; i < 8; i++)
		begin
			words[i] = dataWidth'($urandom);
			writeReg(regVramRw, words[i]);
		end
		// Reload with junk above the address bits
		for (int i = 0; i < 8; i++)
		begin
			got = dataWidth'((base + i * int'(stride)) % ramDepth);
			writeReg(regVramAddr, got | (dataWidth'($urandom) << vramAddrWidth));
			readReg(regVramRw, got);
			checkValue("vram word", got, words[i]);
		end

		// Reads leave the address alone
		writeReg(regVramAddr, dataWidth'(base));
		readReg(regVramRw, first);
		readReg(regVramAddr, got);
		checkValue("repeat read", got, first);
		checkValue("vram word at base", first, words[0]);

		// Unused indices
		for (int idx = 4; idx < 8; idx++)
		begin
			writeReg(regAddrWidth'(idx), dataWidth'($urandom));
			readReg(regAddrWidth'(idx), got);
			checkValue("unused register", got, 0);
		end

		// Sync windows over three frames
		idleCycles(3 * frameCycles);

		// Six frames at each random speed with mode reads in between
		repeat (3)
		begin
			speed = $urandom % 4;
			writeReg(regLspcMode, {8'(speed), 4'($urandom), 1'b0, 3'($urandom)});
			repeat (6)
			begin
				idleCycles(frameCycles - 20 + $urandom % 16);
				readReg(regLspcMode, got);
			end
		end

		// Disabled counter holds the tile the model reached
		writeReg(regLspcMode, 16'h0008);
		frozen = shadowAa;
		idleCycles(3 * frameCycles);
		checkValue("aaCount while disabled", aaCount, frozen);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* design/autoAnim.sv */
// LSPC auto-animation
// Divides frame pulses by aaSpeed+1 and steps the 3-bit tile counter

`timescale 1ns/10ps

module autoAnim
	import lspcPkg::*;
(
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic frameStart,
	input logic [aaSpeedWidth-1:0] aaSpeed,
	input logic aaDisable,
	output logic [aaCountWidth-1:0] aaCount
);

	// Frames seen since the last step
	logic [aaSpeedWidth-1:0] frameDiv;
	// Divider reached the programmed speed
	logic divDone;
	logic frameTick;

	// Also catches a speed lowered below the running count
	assign divDone = (frameDiv >= aaSpeed);
	// Nothing moves while disabled
	assign frameTick = frameStart && !aaDisable;

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			frameDiv <= '0;
			aaCount <= '0;
		end
		else if (frameTick)
		begin
			if (divDone)
			begin
				// Step tile, restart divider
				frameDiv <= '0;
				aaCount <= aaCount + 1'b1;
			end
			else
				frameDiv <= frameDiv + 1'b1;
		end
	end

endmodule

/* design/cpuRegs.sv */
// LSPC CPU register port
// Strobe decode, modulo and mode registers, registered read data

`timescale 1ns/10ps

module cpuRegs
	import lspcPkg::*;
(
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic [regAddrWidth-1:0] regAddr,
	input logic [dataWidth-1:0] wrData,
	input logic wrStrobe,
	input logic rdStrobe,
	input logic [rasterWidth-1:0] rasterLine,
	input logic [aaCountWidth-1:0] aaCount,
	input logic [dataWidth-1:0] ramReadData,
	output logic [dataWidth-1:0] rdData,
	output logic rdValid,
	output logic addrLoad,
	output logic ramWrite,
	output logic [dataWidth-1:0] ramWriteData,
	output logic [dataWidth-1:0] modulo,
	output logic [aaSpeedWidth-1:0] aaSpeed,
	output logic aaDisable
);

	// Write decode
	logic wrMod;
	logic wrMode;
	// Mode word, both directions
	lspcModeWord modeIn;
	lspcModeWord modeOut;
	// Read mux output
	logic [dataWidth-1:0] readWord;

	// ==================================================
	// Write side
	// ==================================================

	// RAM accesses go straight to the VRAM port
	assign addrLoad = wrStrobe && (regAddr == regVramAddr);
	assign ramWrite = wrStrobe && (regAddr == regVramRw);
	assign ramWriteData = wrData;

	assign wrMod = wrStrobe && (regAddr == regVramMod);
	assign wrMode = wrStrobe && (regAddr == regLspcMode);

	// Incoming word through the write view
	assign modeIn = wrData;

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			modulo <= '0;
			aaSpeed <= '0;
			aaDisable <= 1'b0;
		end
		else
		begin
			if (wrMod)
				modulo <= wrData;
			// Speed and disable only, spare bits dropped
			if (wrMode)
			begin
				aaSpeed <= modeIn.writeView.aaSpeed;
				aaDisable <= modeIn.writeView.aaDisable;
			end
		end
	end

	// ==================================================
	// Read side
	// ==================================================

	// Live status through the read view
	always_comb
	begin
		modeOut = '0;
		modeOut.readView.rasterLine = rasterLine;
		modeOut.readView.aaCount = aaCount;
	end

	always_comb
	begin
		case (regAddr)
			// Both RAM registers show the addressed word
			regVramAddr, regVramRw: readWord = ramReadData;
			regVramMod: readWord = modulo;
			regLspcMode: readWord = modeOut;
			default: readWord = '0;
		endcase
	end

	// Valid one cycle after the strobe
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			rdValid <= 1'b0;
		else
			rdValid <= rdStrobe;
	end

	// Data captured in the strobe cycle
	always_ff @(posedge CLK_24M)
	begin
		if (rdStrobe)
			rdData <= readWord;
	end

	// CPU never reads and writes in the same cycle
	strobeExclusive: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!(wrStrobe && rdStrobe));

endmodule

/* design/lspcPkg.sv */
// LSPC shared definitions
// Bus and RAM widths, CPU register indices and the mode register word

package lspcPkg;

	// ==================================================
	// Widths
	// ==================================================

	// CPU data bus and video RAM word
	localparam int dataWidth = 16;
	// Register word index on the CPU bus
	localparam int regAddrWidth = 3;
	// Raster line counter, wide enough for a full frame
	localparam int rasterWidth = 9;
	// Auto-animation tile number
	localparam int aaCountWidth = 3;
	// Auto-animation frame divider
	localparam int aaSpeedWidth = 8;

	// ==================================================
	// CPU register indices
	// ==================================================

	localparam logic [regAddrWidth-1:0] regVramAddr = 3'd0;
	localparam logic [regAddrWidth-1:0] regVramRw = 3'd1;
	localparam logic [regAddrWidth-1:0] regVramMod = 3'd2;
	localparam logic [regAddrWidth-1:0] regLspcMode = 3'd3;

	// Mode register as the CPU writes it
	typedef struct packed {
		logic [aaSpeedWidth-1:0] aaSpeed;
		logic [3:0] spareHigh;
		logic aaDisable;
		logic [2:0] spareLow;
	} lspcModeWrite;

	// Mode register as the CPU reads it
	typedef struct packed {
		logic [rasterWidth-1:0] rasterLine;
		logic [3:0] spare;
		logic [aaCountWidth-1:0] aaCount;
	} lspcModeRead;

	// Same address, different meaning per direction
	typedef union packed {
		lspcModeWrite writeView;
		lspcModeRead readView;
	} lspcModeWord;

endpackage

/* design/lspcTop.sv */
// LSPC display core top level
// CPU register port, video RAM, video timing and auto-animation

`timescale 1ns/10ps

module lspcTop
	import lspcPkg::*;
#(
	parameter int vramAddrWidth = 11,
	parameter int lineLength = 384,
	parameter int linesPerFrame = 264,
	parameter int hsyncWidth = 32,
	parameter int vsyncLines = 8
)
(
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic [regAddrWidth-1:0] regAddr,
	input logic [dataWidth-1:0] wrData,
	input logic wrStrobe,
	input logic rdStrobe,
	output logic [dataWidth-1:0] rdData,
	output logic rdValid,
	output logic hsync,
	output logic vsync,
	output logic [aaCountWidth-1:0] aaCount
);

	// ==================================================
	// Internal nets
	// ==================================================

	// Register port to VRAM
	logic addrLoad;
	logic ramWrite;
	logic [dataWidth-1:0] ramWriteData;
	logic [dataWidth-1:0] modulo;
	logic [dataWidth-1:0] ramReadData;
	// Mode register to auto-animation
	logic [aaSpeedWidth-1:0] aaSpeed;
	logic aaDisable;
	// Timing outputs
	logic [rasterWidth-1:0] rasterLine;
	logic frameStart;

	cpuRegs i_cpuRegs (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT), .regAddr(regAddr), .wrData(wrData),
		.wrStrobe(wrStrobe), .rdStrobe(rdStrobe), .rasterLine(rasterLine),
		.aaCount(aaCount), .ramReadData(ramReadData), .rdData(rdData), .rdValid(rdValid),
		.addrLoad(addrLoad), .ramWrite(ramWrite), .ramWriteData(ramWriteData),
		.modulo(modulo), .aaSpeed(aaSpeed), .aaDisable(aaDisable)
	);

	vramPort #(.vramAddrWidth(vramAddrWidth)) i_vramPort (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT), .addrLoad(addrLoad), .ramWrite(ramWrite),
		.ramWriteData(ramWriteData), .modulo(modulo), .ramReadData(ramReadData)
	);

	// Frame geometry comes from the top parameters
	videoCounters #(
		.lineLength(lineLength), .linesPerFrame(linesPerFrame),
		.hsyncWidth(hsyncWidth), .vsyncLines(vsyncLines)
	) i_videoCounters (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT), .rasterLine(rasterLine),
		.frameStart(frameStart), .hsync(hsync), .vsync(vsync)
	);

	autoAnim i_autoAnim (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT), .frameStart(frameStart),
		.aaSpeed(aaSpeed), .aaDisable(aaDisable), .aaCount(aaCount)
	);

endmodule

/* design/videoCounters.sv */
// LSPC video timing
// Pixel and raster counters, sync windows and start-of-frame pulse

`timescale 1ns/10ps

module videoCounters
	import lspcPkg::*;
#(
	parameter int lineLength = 384,
	parameter int linesPerFrame = 264,
	parameter int hsyncWidth = 32,
	parameter int vsyncLines = 8
)
(
	input logic CLK_24M,
	input logic T73A_OUT,
	output logic [rasterWidth-1:0] rasterLine,
	output logic frameStart,
	output logic hsync,
	output logic vsync
);

	localparam int pixelWidth = $clog2(lineLength);

	logic [pixelWidth-1:0] pixelCount;
	logic [rasterWidth-1:0] rasterCount;
	// Set once the first frame has wrapped
	logic frameDone;
	// Next-cycle values
	logic [pixelWidth-1:0] pixelNext;
	logic [rasterWidth-1:0] rasterNext;
	logic frameDoneNext;
	logic lastPixel;
	logic lastLine;

	assign lastPixel = (pixelCount == pixelWidth'(lineLength - 1));
	assign lastLine = (rasterCount == rasterWidth'(linesPerFrame - 1));

	always_comb
	begin
		pixelNext = lastPixel ? '0 : pixelCount + 1'b1;
		rasterNext = rasterCount;
		// Line advances on pixel wrap
		if (lastPixel)
			rasterNext = lastLine ? '0 : rasterCount + 1'b1;
		frameDoneNext = frameDone || (lastPixel && lastLine);
	end

	// Sync registered from next counts, inactive through reset
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			pixelCount <= '0;
			rasterCount <= '0;
			frameDone <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			pixelCount <= pixelNext;
			rasterCount <= rasterNext;
			frameDone <= frameDoneNext;
			hsync <= !(pixelNext < pixelWidth'(hsyncWidth));
			vsync <= !(frameDoneNext && (rasterNext < rasterWidth'(vsyncLines)));
		end
	end

	// Counter origin, skipped straight after reset
	assign frameStart = frameDone && (pixelCount == '0) && (rasterCount == '0);
	assign rasterLine = rasterCount;

	pixelInRange: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		pixelCount < pixelWidth'(lineLength));

endmodule

/* design/vramPort.sv */
// LSPC video RAM port
// Single-port RAM with CPU address register and modulo auto-increment

`timescale 1ns/10ps

module vramPort
	import lspcPkg::*;
#(
	parameter int vramAddrWidth = 11
)
(
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic addrLoad,
	input logic ramWrite,
	input logic [dataWidth-1:0] ramWriteData,
	input logic [dataWidth-1:0] modulo,
	output logic [dataWidth-1:0] ramReadData
);

	localparam int ramDepth = 2 ** vramAddrWidth;

	// ==================================================
	// Storage
	// ==================================================

	logic [dataWidth-1:0] ram [ramDepth];
	// Current CPU address
	logic [vramAddrWidth-1:0] vramAddr;
	// Address after a write
	logic [vramAddrWidth-1:0] nextAddr;
	// Modulo reduced to the RAM size
	logic [vramAddrWidth-1:0] addrStep;

	// Upper modulo bits fall off, so the sum wraps at the RAM size
	assign addrStep = modulo[vramAddrWidth-1:0];
	assign nextAddr = vramAddr + addrStep;

	// ==================================================
	// Address register
	// ==================================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			vramAddr <= '0;
		else
		begin
			// Load from the low bits of the written word
			if (addrLoad)
				vramAddr <= ramWriteData[vramAddrWidth-1:0];
			// Auto-increment after each data write
			else if (ramWrite)
				vramAddr <= nextAddr;
		end
	end

	// ==================================================
	// RAM array
	// ==================================================

	// Write lands at the address before the increment
	always_ff @(posedge CLK_24M)
	begin
		if (ramWrite)
			ram[vramAddr] <= ramWriteData;
	end

	// Asynchronous read at the current address
	assign ramReadData = ram[vramAddr];

	// Register decode hands over at most one update per cycle
	oneAddrUpdate: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!(addrLoad && ramWrite));

endmodule

/* lspcVideo.f */
+incdir+bench
design/lspcPkg.sv
design/cpuRegs.sv
design/vramPort.sv
design/videoCounters.sv
design/autoAnim.sv
design/lspcTop.sv
bench/lspcTb.sv
